/* hw/cpu_pkg.sv */
package cpu_pkg;

  //////////////////////////////////////////////////
  // sizes

  localparam int word_width = 32;
  localparam int code_words = 16;
  localparam int code_addr_width = $clog2(code_words);
  // byte address of the code memory, wraps at 64
  localparam int pc_width = code_addr_width + 2;
  localparam int reg_idx_width = 4;

  localparam logic [reg_idx_width-1:0] reg_lr = 4'd14;
  localparam logic [reg_idx_width-1:0] reg_pc = 4'd15;

  //////////////////////////////////////////////////
  // instruction fields

  localparam logic [3:0] opcode_and = 4'b0000;
  localparam logic [3:0] opcode_eor = 4'b0001;
  localparam logic [3:0] opcode_sub = 4'b0010;
  localparam logic [3:0] opcode_rsb = 4'b0011;
  localparam logic [3:0] opcode_add = 4'b0100;
  localparam logic [3:0] opcode_adc = 4'b0101;
  localparam logic [3:0] opcode_sbc = 4'b0110;
  localparam logic [3:0] opcode_rsc = 4'b0111;
  localparam logic [3:0] opcode_tst = 4'b1000;
  localparam logic [3:0] opcode_teq = 4'b1001;
  localparam logic [3:0] opcode_cmp = 4'b1010;
  localparam logic [3:0] opcode_cmn = 4'b1011;
  localparam logic [3:0] opcode_orr = 4'b1100;
  localparam logic [3:0] opcode_mov = 4'b1101;
  localparam logic [3:0] opcode_bic = 4'b1110;
  localparam logic [3:0] opcode_mvn = 4'b1111;

  localparam logic [3:0] cond_eq = 4'b0000;
  localparam logic [3:0] cond_ne = 4'b0001;
  localparam logic [3:0] cond_cs = 4'b0010;
  localparam logic [3:0] cond_cc = 4'b0011;
  localparam logic [3:0] cond_ns = 4'b0100;
  localparam logic [3:0] cond_nc = 4'b0101;
  localparam logic [3:0] cond_vs = 4'b0110;
  localparam logic [3:0] cond_vc = 4'b0111;
  localparam logic [3:0] cond_hi = 4'b1000;
  localparam logic [3:0] cond_ls = 4'b1001;
  localparam logic [3:0] cond_ge = 4'b1010;
  localparam logic [3:0] cond_lt = 4'b1011;
  localparam logic [3:0] cond_gt = 4'b1100;
  localparam logic [3:0] cond_le = 4'b1101;
  localparam logic [3:0] cond_al = 4'b1110;

  localparam logic [1:0] inst_type_data_proc = 2'b00;
  localparam logic [1:0] inst_type_branch = 2'b10;

  //////////////////////////////////////////////////
  // instruction word

  // low byte is either an immediate or a register
  typedef struct packed {
    logic [3:0] unused;
    logic [reg_idx_width-1:0] rm;
  } op2_reg_t;

  typedef union packed {
    logic [7:0] imm8;
    op2_reg_t rg;
  } op2_u;

  typedef struct packed {
    logic [3:0] cond;
    logic [1:0] itype;
    logic imm;
    logic [3:0] opcode;
    logic s;
    logic [reg_idx_width-1:0] rn;
    logic [reg_idx_width-1:0] rd;
    logic [3:0] unused;
    op2_u op2;
  } inst_dp_t;

  typedef struct packed {
    logic [3:0] cond;
    logic [1:0] itype;
    // bit 25, set in every branch encoding
    logic fixed_one;
    logic link;
    logic [23:0] offset;
  } inst_br_t;

  typedef union packed {
    inst_dp_t dp;
    inst_br_t br;
  } inst_u;

  //////////////////////////////////////////////////
  // pipeline bundles

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flags_t;

  typedef struct packed {
    logic valid;
    logic [word_width-1:0] pc;
    inst_u inst;
  } fd_t;

  typedef struct packed {
    logic valid;
    logic [word_width-1:0] pc;
    inst_u inst;
    logic [word_width-1:0] op1;
    logic [word_width-1:0] op2;
  } de_t;

  typedef struct packed {
    logic we;
    logic [reg_idx_width-1:0] idx;
    logic [word_width-1:0] data;
  } wb_t;

endpackage

/* hw/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit
  import cpu_pkg::*;
(
  input  logic clk,
  input  logic nreset,
  input  logic prog_we,
  input  logic [code_addr_width-1:0] prog_addr,
  input  logic [word_width-1:0] prog_data,
  input  logic redirect,
  input  logic [word_width-1:0] target,
  output fd_t fd
);

  logic [word_width-1:0] code_mem [0:code_words-1];
  logic [pc_width-1:0] pc;
  logic [word_width-1:0] code_rd;

  //////////////////////////////////////////////////
  // code memory

  // load port, only used while the core is held in reset
  always_ff @(posedge clk) begin
    if (prog_we) begin
      code_mem[prog_addr] <= prog_data;
    end
  end

  assign code_rd = code_mem[pc[pc_width-1:2]];

  //////////////////////////////////////////////////
  // pc and fetch register

  always_ff @(posedge clk) begin
    fd.pc <= {{(word_width - pc_width){1'b0}}, pc};
    fd.inst <= code_rd;
    if (!nreset) begin
      pc <= '0;
      fd.valid <= 1'b0;
    end else if (redirect) begin
      // taken branch, the word fetched this cycle is dropped
      pc <= target[pc_width-1:0];
      fd.valid <= 1'b0;
    end else begin
      // wraps at the end of code memory
      pc <= pc + pc_width'(4);
      fd.valid <= 1'b1;
    end
  end

endmodule

/* hw/reg_file.sv */
`timescale 1ns/1ps

module reg_file
  import cpu_pkg::*;
(
  input  logic clk,
  input  logic nreset,
  input  logic [reg_idx_width-1:0] rs1,
  input  logic [reg_idx_width-1:0] rs2,
  input  logic [word_width-1:0] rs_pc,
  input  wb_t wb,
  output logic [word_width-1:0] rd1,
  output logic [word_width-1:0] rd2
);

  // r0..r14, r15 is the pc
  logic [word_width-1:0] regs [0:reg_pc-1];

  function automatic logic [word_width-1:0] read_port(input logic [reg_idx_width-1:0] idx);
    // r15 reads two instructions ahead
    if (idx == reg_pc) begin
      return rs_pc + word_width'(8);
    end
    return regs[idx];
  endfunction

  always_comb begin
    rd1 = read_port(rs1);
    rd2 = read_port(rs2);
  end

  always_ff @(posedge clk) begin
    if (!nreset) begin
      for (int i = 0; i < reg_pc; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.we && wb.idx != reg_pc) begin
      regs[wb.idx] <= wb.data;
    end
  end

endmodule

/* hw/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage
  import cpu_pkg::*;
(
  input  logic clk,
  input  logic nreset,
  input  fd_t fd,
  input  logic redirect,
  input  wb_t wb,
  input  logic [word_width-1:0] rd1,
  input  logic [word_width-1:0] rd2,
  output logic [reg_idx_width-1:0] rs1,
  output logic [reg_idx_width-1:0] rs2,
  output logic [word_width-1:0] rs_pc,
  output de_t de
);

  logic [word_width-1:0] rn_val;
  logic [word_width-1:0] rm_val;
  logic [word_width-1:0] op2;

  // execute result bypasses the register file
  function automatic logic [word_width-1:0] fwd(
    input logic [reg_idx_width-1:0] idx,
    input logic [word_width-1:0] rf_val,
    input wb_t w
  );
    if (w.we && w.idx == idx) begin
      return w.data;
    end
    return rf_val;
  endfunction

  //////////////////////////////////////////////////
  // register read

  assign rs1 = fd.inst.dp.rn;
  assign rs2 = fd.inst.dp.op2.rg.rm;
  assign rs_pc = fd.pc;

  assign rn_val = fwd(rs1, rd1, wb);
  assign rm_val = fwd(rs2, rd2, wb);

  // immediate is zero extended, no rotate
  always_comb begin
    if (fd.inst.dp.imm) begin
      op2 = {{(word_width - 8){1'b0}}, fd.inst.dp.op2.imm8};
    end else begin
      op2 = rm_val;
    end
  end

  //////////////////////////////////////////////////
  // decode to execute register

  always_ff @(posedge clk) begin
    de.pc <= fd.pc;
    de.inst <= fd.inst;
    de.op1 <= rn_val;
    de.op2 <= op2;
    if (!nreset) begin
      de.valid <= 1'b0;
    end else begin
      // squashed when the instruction in execute branches
      de.valid <= fd.valid && !redirect;
    end
  end

endmodule

/* hw/execute_unit.sv */
`timescale 1ns/1ps

module execute_unit
  import cpu_pkg::*;
(
  input  logic clk,
  input  logic nreset,
  input  de_t de,
  output wb_t wb,
  output logic redirect,
  output logic [word_width-1:0] target
);

  flags_t flags;
  flags_t flags_next;
  logic cond_ok;
  logic active;
  logic is_dp;
  logic is_br;
  logic arith;
  logic carry_in;
  logic writes_rd;
  logic [word_width-1:0] add_x;
  logic [word_width-1:0] add_y;
  logic [word_width-1:0] logic_res;
  logic [word_width:0] sum;
  logic [word_width:0] alu_res;

  function automatic logic cond_check(input logic [3:0] cond, input flags_t f);
    case (cond)
      cond_eq: return f.z;
      cond_ne: return !f.z;
      cond_cs: return f.c;
      cond_cc: return !f.c;
      cond_ns: return f.n;
      cond_nc: return !f.n;
      cond_vs: return f.v;
      cond_vc: return !f.v;
      cond_hi: return f.c && !f.z;
      cond_ls: return !f.c || f.z;
      cond_ge: return f.n == f.v;
      cond_lt: return f.n != f.v;
      cond_gt: return !f.z && (f.n == f.v);
      cond_le: return f.z || (f.n != f.v);
      cond_al: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  assign cond_ok = cond_check(de.inst.dp.cond, flags);
  assign active = de.valid && cond_ok;
  assign is_dp = de.inst.dp.itype == inst_type_data_proc;
  assign is_br = de.inst.br.itype == inst_type_branch;

  //////////////////////////////////////////////////
  // alu

  // subtracting forms add the inverted operand
  always_comb begin
    arith = 1'b1;
    add_x = de.op1;
    add_y = de.op2;
    carry_in = 1'b0;
    logic_res = '0;
    case (de.inst.dp.opcode)
      opcode_sub, opcode_cmp: begin
        add_y = ~de.op2;
        carry_in = 1'b1;
      end
      opcode_rsb: begin
        add_x = de.op2;
        add_y = ~de.op1;
        carry_in = 1'b1;
      end
      opcode_add, opcode_cmn: carry_in = 1'b0;
      opcode_adc: carry_in = flags.c;
      opcode_sbc: begin
        add_y = ~de.op2;
        carry_in = flags.c;
      end
      opcode_rsc: begin
        add_x = de.op2;
        add_y = ~de.op1;
        carry_in = flags.c;
      end
      opcode_and, opcode_tst: begin
        arith = 1'b0;
        logic_res = de.op1 & de.op2;
      end
      opcode_eor, opcode_teq: begin
        arith = 1'b0;
        logic_res = de.op1 ^ de.op2;
      end
      opcode_orr: begin
        arith = 1'b0;
        logic_res = de.op1 | de.op2;
      end
      opcode_mov: begin
        arith = 1'b0;
        logic_res = de.op2;
      end
      opcode_bic: begin
        arith = 1'b0;
        logic_res = de.op1 & ~de.op2;
      end
      default: begin
        // mvn
        arith = 1'b0;
        logic_res = ~de.op2;
      end
    endcase
  end

  assign sum = {1'b0, add_x} + {1'b0, add_y} + {{word_width{1'b0}}, carry_in};
  assign alu_res = arith ? sum : {1'b0, logic_res};

  assign writes_rd = !(de.inst.dp.opcode inside {opcode_tst, opcode_teq, opcode_cmp, opcode_cmn});

  always_comb begin
    flags_next.n = alu_res[word_width-1];
    flags_next.z = alu_res[word_width-1:0] == '0;
    flags_next.c = alu_res[word_width];
    // both addends share a sign the result lacks
    flags_next.v = arith && (add_x[word_width-1] == add_y[word_width-1]) &&
                   (sum[word_width-1] != add_x[word_width-1]);
  end

  always_ff @(posedge clk) begin
    if (!nreset) begin
      flags <= '0;
    end else if (active && is_dp && de.inst.dp.s && de.inst.dp.rd != reg_pc) begin
      flags <= flags_next;
    end
  end

  //////////////////////////////////////////////////
  // writeback and branch

  always_comb begin
    wb = '0;
    if (active && is_dp && writes_rd && de.inst.dp.rd != reg_pc) begin
      wb.we = 1'b1;
      wb.idx = de.inst.dp.rd;
      wb.data = alu_res[word_width-1:0];
    end else if (active && is_br && de.inst.br.link) begin
      // link holds the address of the next instruction
      wb.we = 1'b1;
      wb.idx = reg_lr;
      wb.data = de.pc + word_width'(4);
    end
  end

  assign redirect = active && is_br;
  assign target = de.pc + word_width'(8) +
                  {{(word_width - 26){de.inst.br.offset[23]}}, de.inst.br.offset, 2'b00};

endmodule

/* hw/cpu_core.sv */
`timescale 1ns/1ps

module cpu_core
  import cpu_pkg::*;
(
  input  logic clk,
  input  logic nreset,
  input  logic prog_we,
  input  logic [code_addr_width-1:0] prog_addr,
  input  logic [word_width-1:0] prog_data,
  output logic led,
  output wb_t trace
);

  fd_t fd;
  de_t de;
  wb_t wb;
  logic redirect;
  logic [word_width-1:0] target;
  logic [reg_idx_width-1:0] rs1;
  logic [reg_idx_width-1:0] rs2;
  logic [word_width-1:0] rs_pc;
  logic [word_width-1:0] rd1;
  logic [word_width-1:0] rd2;

  fetch_unit i_fetch_unit (
    .clk       (clk),
    .nreset    (nreset),
    .prog_we   (prog_we),
    .prog_addr (prog_addr),
    .prog_data (prog_data),
    .redirect  (redirect),
    .target    (target),
    .fd        (fd)
  );

  reg_file i_reg_file (
    .clk    (clk),
    .nreset (nreset),
    .rs1    (rs1),
    .rs2    (rs2),
    .rs_pc  (rs_pc),
    .wb     (wb),
    .rd1    (rd1),
    .rd2    (rd2)
  );

  decode_stage i_decode_stage (
    .clk      (clk),
    .nreset   (nreset),
    .fd       (fd),
    .redirect (redirect),
    .wb       (wb),
    .rd1      (rd1),
    .rd2      (rd2),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs_pc    (rs_pc),
    .de       (de)
  );

  execute_unit i_execute_unit (
    .clk      (clk),
    .nreset   (nreset),
    .de       (de),
    .wb       (wb),
    .redirect (redirect),
    .target   (target)
  );

  // blinks with the fetch address
  assign led = fd.pc[2];
  assign trace = wb;

endmodule

/* tb/cpu_model.svh */
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

//////////////////////////////////////////////////
// instruction encoders

function automatic logic [31:0] dp_imm(input logic [3:0] cond, input logic [3:0] op,
                                       input logic s, input logic [3:0] rd,
                                       input logic [3:0] rn, input logic [7:0] imm);
  return {cond, inst_type_data_proc, 1'b1, op, s, rn, rd, 4'b0000, imm};
endfunction

function automatic logic [31:0] dp_reg(input logic [3:0] cond, input logic [3:0] op,
                                       input logic s, input logic [3:0] rd,
                                       input logic [3:0] rn, input logic [3:0] rm);
  return {cond, inst_type_data_proc, 1'b0, op, s, rn, rd, 4'b0000, 4'b0000, rm};
endfunction

function automatic logic [31:0] br(input logic [3:0] cond, input logic link,
                                   input logic [23:0] offset);
  return {cond, inst_type_branch, 1'b1, link, offset};
endfunction

//////////////////////////////////////////////////
// architectural reference

// condition codes come in pairs, the odd one negates the even one
function automatic logic cond_pass(input logic [3:0] cond, input flags_t f);
  logic base;
  case (cond[3:1])
    3'd0: base = f.z;
    3'd1: base = f.c;
    3'd2: base = f.n;
    3'd3: base = f.v;
    3'd4: base = f.c && !f.z;
    3'd5: base = f.n == f.v;
    3'd6: base = !f.z && (f.n == f.v);
    default: base = 1'b1;
  endcase
  // always for 1110, never for 1111
  if (cond[3:1] == 3'd7) begin
    return !cond[0];
  end
  return base ^ cond[0];
endfunction

// runs prog from address 0 until the branch to itself, fills exp_q
function automatic void run_model();
  logic [31:0] regs [0:14];
  flags_t f;
  logic [5:0] pc;
  logic [31:0] inst;
  logic [31:0] pc32;
  logic [31:0] tgt;
  logic [31:0] x;
  logic [31:0] y;
  logic [31:0] res;
  logic [32:0] r33;
  logic [3:0] op;
  logic [3:0] rd;
  logic cin;
  logic arith;
  logic stop;
  int steps;
  exp_q.delete();
  for (int i = 0; i < 15; i++) begin
    regs[i] = '0;
  end
  f = '0;
  pc = '0;
  stop = 1'b0;
  steps = 0;
  while (!stop && steps < 64) begin
    inst = prog[pc[5:2]];
    pc32 = {26'd0, pc};
    steps++;
    if (!cond_pass(inst[31:28], f)) begin
      pc = pc + 6'd4;
    end else if (inst[27:26] == inst_type_branch) begin
      tgt = pc32 + 32'd8 + {{6{inst[23]}}, inst[23:0], 2'b00};
      if (inst[24]) begin
        regs[14] = pc32 + 32'd4;
        exp_q.push_back({1'b1, reg_lr, pc32 + 32'd4});
      end
      if (tgt[5:0] == pc) begin
        stop = 1'b1;
      end
      pc = tgt[5:0];
    end else begin
      op = inst[24:21];
      rd = inst[15:12];
      x = (inst[19:16] == reg_pc) ? pc32 + 32'd8 : regs[inst[19:16]];
      if (inst[25]) begin
        y = {24'd0, inst[7:0]};
      end else begin
        y = (inst[3:0] == reg_pc) ? pc32 + 32'd8 : regs[inst[3:0]];
      end
      arith = 1'b1;
      cin = 1'b0;
      res = '0;
      case (op)
        opcode_sub, opcode_cmp: begin
          y = ~y;
          cin = 1'b1;
        end
        opcode_rsb: begin
          res = x;
          x = y;
          y = ~res;
          cin = 1'b1;
        end
        opcode_adc: cin = f.c;
        opcode_sbc: begin
          y = ~y;
          cin = f.c;
        end
        opcode_rsc: begin
          res = x;
          x = y;
          y = ~res;
          cin = f.c;
        end
        opcode_add, opcode_cmn: cin = 1'b0;
        default: arith = 1'b0;
      endcase
      case (op)
        opcode_and, opcode_tst: res = x & y;
        opcode_eor, opcode_teq: res = x ^ y;
        opcode_orr: res = x | y;
        opcode_mov: res = y;
        opcode_bic: res = x & ~y;
        opcode_mvn: res = ~y;
        default: res = '0;
      endcase
      r33 = arith ? ({1'b0, x} + {1'b0, y} + {32'd0, cin}) : {1'b0, res};
      if (inst[20] && rd != reg_pc) begin
        f.n = r33[31];
        f.z = (r33[31:0] == 32'd0);
        f.c = r33[32];
        f.v = arith && (x[31] == y[31]) && (r33[31] != x[31]);
      end
      if (!(op inside {opcode_tst, opcode_teq, opcode_cmp, opcode_cmn}) && rd != reg_pc) begin
        regs[rd] = r33[31:0];
        exp_q.push_back({1'b1, rd, r33[31:0]});
      end
      pc = pc + 6'd4;
    end
  end
endfunction

`endif

/* tb/tb_cpu_core.sv */
`timescale 1ns/1ps

module tb_cpu_core
  import cpu_pkg::*;
();

  localparam int run_cycles = code_words + 7 + 60;
  localparam int num_runs = 13;
  localparam int watchdog_ns = num_runs * run_cycles * 4 + 400;

  logic clk = 1'b0;
  logic nreset;
  logic prog_we;
  logic [code_addr_width-1:0] prog_addr;
  logic [word_width-1:0] prog_data;
  logic led;
  wb_t trace;

  logic [31:0] prog [0:15];
  logic [31:0] prog_q [$];
  wb_t exp_q [$];
  wb_t exp_w;
  logic checking = 1'b0;
  int seed = 91;
  int errors = 0;
  int tests_run = 0;
  int tests_failed = 0;

  `include "cpu_model.svh"

  cpu_core i_cpu_core (
    .clk       (clk),
    .nreset    (nreset),
    .prog_we   (prog_we),
    .prog_addr (prog_addr),
    .prog_data (prog_data),
    .led       (led),
    .trace     (trace)
  );

  always #2 clk = ~clk;

  //////////////////////////////////////////////////
  // compare trace against the model

  always @(posedge clk) begin
    if (checking && trace.we === 1'b1) begin
      if (exp_q.size() == 0) begin
        $display("unexpected write of %h to r%0d", trace.data, trace.idx);
        errors++;
      end else begin
        exp_w = exp_q.pop_front();
        if (trace.idx !== exp_w.idx) begin
          $display("Mismatch trace.idx: got %h expected %h", trace.idx, exp_w.idx);
          errors++;
        end
        if (trace.data !== exp_w.data) begin
          $display("Mismatch trace.data: got %h expected %h", trace.data, exp_w.data);
          errors++;
        end
      end
    end
  end

  initial begin
    #(watchdog_ns);
    $display("watchdog expired before the tests finished");
    $display("Some tests failed");
    $finish;
  end

  //////////////////////////////////////////////////
  // program building and running

  function automatic logic [7:0] rand_byte();
    return 8'($random(seed));
  endfunction

  task automatic emit(input logic [31:0] word);
    prog_q.push_back(word);
  endtask

  task automatic run_program();
    for (int i = 0; i < 16; i++) begin
      prog[i] = (i < prog_q.size()) ? prog_q[i] : 32'd0;
    end
    run_model();
    @(posedge clk);
    nreset <= 1'b0;
    for (int i = 0; i < 16; i++) begin
      @(posedge clk);
      prog_we <= 1'b1;
      prog_addr <= 4'(i);
      prog_data <= prog[i];
    end
    @(posedge clk);
    prog_we <= 1'b0;
    // core must stay quiet while held in reset
    repeat (4) begin
      @(posedge clk);
      if (trace.we !== 1'b0) begin
        $display("register write seen while in reset");
        errors++;
      end
      if (led !== 1'b0) begin
        $display("Mismatch led: got %h expected %h", led, 1'b0);
        errors++;
      end
    end
    @(posedge clk);
    nreset <= 1'b1;
    checking = 1'b1;
    repeat (60) @(posedge clk);
    checking = 1'b0;
    if (exp_q.size() != 0) begin
      $display("%0d expected register writes never appeared", exp_q.size());
      errors++;
      exp_q.delete();
    end
    prog_q.delete();
  endtask

  task automatic report(input int num, input string name, input int err_before);
    tests_run++;
    if (errors == err_before) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", num, name, errors - err_before);
    end
  endtask

  task automatic alu_prog(input int first_op, input logic use_imm);
    emit(dp_imm(cond_al, opcode_mov, 1'b0, 4'd1, 4'd0, rand_byte()));
    emit(dp_imm(cond_al, opcode_orr, 1'b0, 4'd1, 4'd1, rand_byte()));
    emit(dp_imm(cond_al, opcode_mov, 1'b0, 4'd2, 4'd0, rand_byte()));
    for (int k = 0; k < 8; k++) begin
      if (use_imm) begin
        emit(dp_imm(cond_al, 4'(first_op + k), 1'b1, 4'(3 + k), 4'd1, rand_byte()));
      end else begin
        emit(dp_reg(cond_al, 4'(first_op + k), 1'b1, 4'(3 + k), 4'd1, 4'd2));
      end
    end
    emit(br(cond_al, 1'b0, 24'hfffffe));
  endtask

  // compare sets the flags, then a run of conditional adds
  task automatic cond_prog(input logic [7:0] a, input logic [7:0] b, input int first_cond,
                           input int count);
    emit(dp_imm(cond_al, opcode_mov, 1'b0, 4'd1, 4'd0, a));
    emit(dp_imm(cond_al, opcode_mov, 1'b0, 4'd2, 4'd0, b));
    emit(dp_reg(cond_al, opcode_cmp, 1'b1, 4'd0, 4'd1, 4'd2));
    for (int k = 0; k < count; k++) begin
      emit(dp_imm(4'(first_cond + k), opcode_add, 1'b0, 4'(3 + k), 4'd1, 8'(first_cond + k)));
    end
    emit(br(cond_al, 1'b0, 24'hfffffe));
  endtask

  //////////////////////////////////////////////////
  // tests

  initial begin
    int err_before;
    logic [7:0] a;
    nreset <= 1'b0;
    prog_we <= 1'b0;
    prog_addr <= '0;
    prog_data <= '0;
    repeat (2) @(posedge clk);

    err_before = errors;
    emit(dp_imm(cond_al, opcode_mov, 1'b0, 4'd1, 4'd0, 8'h5a));
    emit(br(cond_al, 1'b0, 24'hfffffe));
    run_program();
    report(1, "reset", err_before);

    err_before = errors;
    for (int g = 0; g < 2; g++) begin
      alu_prog(0, g[0]);
      run_program();
      alu_prog(8, g[0]);
      run_program();
    end
    report(2, "alu opcodes", err_before);

    err_before = errors;
    emit(dp_imm(cond_al, opcode_mov, 1'b0, 4'd1, 4'd0, rand_byte()));
    emit(dp_reg(cond_al, opcode_add, 1'b0, 4'd2, 4'd1, 4'd1));
    emit(dp_reg(cond_al, opcode_add, 1'b0, 4'd3, 4'd2, 4'd1));
    emit(dp_reg(cond_al, opcode_sub, 1'b0, 4'd4, 4'd3, 4'd2));
    emit(dp_reg(cond_al, opcode_eor, 1'b0, 4'd5, 4'd4, 4'd3));
    emit(dp_reg(cond_al, opcode_orr, 1'b0, 4'd6, 4'd5, 4'd4));
    emit(dp_imm(cond_al, opcode_add, 1'b0, 4'd6, 4'd6, 8'd1));
    emit(dp_reg(cond_al, opcode_add, 1'b0, 4'd6, 4'd6, 4'd6));
    emit(br(cond_al, 1'b0, 24'hfffffe));
    run_program();
    report(3, "forwarding", err_before);

    err_before = errors;
    for (int p = 0; p < 3; p++) begin
      a = rand_byte();
      cond_prog(a, (p == 2) ? a : rand_byte(), 0, 8);
      run_program();
      cond_prog(a, (p == 2) ? a : rand_byte(), 8, 7);
      run_program();
    end
    report(4, "conditions", err_before);

    err_before = errors;
    emit(dp_imm(cond_al, opcode_mov, 1'b0, 4'd1, 4'd0, 8'd1));
    emit(br(cond_al, 1'b1, 24'd1));
    emit(dp_imm(cond_al, opcode_mov, 1'b0, 4'd2, 4'd0, 8'h22));
    emit(dp_imm(cond_al, opcode_mov, 1'b0, 4'd3, 4'd0, 8'h33));
    emit(dp_imm(cond_al, opcode_add, 1'b0, 4'd4, reg_pc, 8'd0));
    emit(dp_imm(cond_al, opcode_cmp, 1'b1, 4'd0, 4'd1, 8'd1));
    emit(br(cond_ne, 1'b0, 24'd1));
    emit(br(cond_eq, 1'b0, 24'd1));
    emit(dp_imm(cond_al, opcode_mov, 1'b0, 4'd5, 4'd0, 8'h55));
    emit(dp_imm(cond_al, opcode_mov, 1'b0, 4'd6, 4'd0, 8'h66));
    emit(br(cond_ne, 1'b1, 24'd0));
    emit(dp_imm(cond_al, opcode_add, 1'b0, 4'd7, reg_lr, 8'd0));
    emit(dp_reg(cond_al, opcode_mov, 1'b0, 4'd8, 4'd0, reg_pc));
    emit(br(cond_al, 1'b1, 24'd0));
    emit(dp_imm(cond_al, opcode_mov, 1'b0, 4'd9, 4'd0, 8'h99));
    emit(br(cond_al, 1'b0, 24'hfffffe));
    run_program();
    report(5, "branches", err_before);

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_cpu_core
FLAGS ?= --binary

FILELIST := pipe_cpu.f
PASS_MSG := All tests passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FLAGS"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

/* pipe_cpu.f */
+incdir+tb
hw/cpu_pkg.sv
hw/fetch_unit.sv
hw/reg_file.sv
hw/decode_stage.sv
hw/execute_unit.sv
hw/cpu_core.sv
tb/tb_cpu_core.sv
